// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;

  typedef logic [data_width-1:0]     word_t;      // datapath word
  typedef logic [reg_addr_width-1:0] reg_addr_t;  // register index

  localparam reg_addr_t reg_ra_zero = '0;  // hardwired zero reg

  // alu operation select
  typedef logic [3:0] alu_op_t;
  localparam alu_op_t alu_add  = 4'd0;
  localparam alu_op_t alu_sub  = 4'd1;
  localparam alu_op_t alu_and  = 4'd2;
  localparam alu_op_t alu_or   = 4'd3;
  localparam alu_op_t alu_xor  = 4'd4;
  localparam alu_op_t alu_nor  = 4'd5;
  localparam alu_op_t alu_slt  = 4'd6;  // signed compare
  localparam alu_op_t alu_sltu = 4'd7;  // unsigned compare
  localparam alu_op_t alu_sll  = 4'd8;
  localparam alu_op_t alu_srl  = 4'd9;
  localparam alu_op_t alu_sra  = 4'd10;

  typedef logic [1:0] mem_op_t;            // bit 0 half, bit 1 signed
  localparam mem_op_t mem_ubyte = 2'b00;
  localparam mem_op_t mem_uhalf = 2'b01;
  localparam mem_op_t mem_sbyte = 2'b10;
  localparam mem_op_t mem_shalf = 2'b11;

  typedef logic [1:0] imm_ext_t;
  localparam imm_ext_t ext_sign = 2'd0;
  localparam imm_ext_t ext_zero = 2'd1;
  localparam imm_ext_t ext_swap = 2'd2;    // lui, imm to upper half

  typedef struct packed {
    logic [5:0] opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } inst_r_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm;
  } inst_i_t;

  // same instruction word, r-type or i-type field view
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_t;

  typedef struct packed {
    logic     write_reg;    // regfile write
    logic     write_mem;    // data mem write
    logic     alu_or_mem;   // wb from mem when set
    logic     mem_partial;  // byte or half access
    mem_op_t  mem_op;
    logic     alu_src_b;    // imm as operand b
    alu_op_t  alu_op;
    logic     reg_dst;      // rd when set, else rt
    imm_ext_t imm_ext;
  } ctrl_t;

  // control carried past execute
  typedef struct packed {
    logic    write_reg;
    logic    write_mem;
    logic    alu_or_mem;
    logic    mem_partial;
    mem_op_t mem_op;
  } mem_ctrl_t;

  typedef struct packed {
    mem_ctrl_t  mem;
    logic       alu_src_b;
    alu_op_t    alu_op;
    logic       reg_dst;
    word_t      a;       // rs value
    word_t      b;       // rt value
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    word_t      imm;     // extended immediate
  } id_ex_t;

  typedef struct packed {
    mem_ctrl_t mem;
    word_t     result;      // alu out, also mem address
    word_t     store_data;  // forwarded rt
    reg_addr_t dst;
  } ex_mem_t;

  typedef struct packed {
    logic      write_reg;
    reg_addr_t dst;
    word_t     data;
  } wb_t;

endpackage

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  mips_pkg::alu_op_t op,
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  logic [4:0]        shamt,
  output mips_pkg::word_t   result
);
  import mips_pkg::*;

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_nor:  result = ~(a | b);
      alu_slt:  result = {31'd0, lt_signed};
      alu_sltu: result = {31'd0, lt_unsigned};
      alu_sll:  result = b << shamt;             // shifts act on rt
      alu_srl:  result = b >> shamt;
      alu_sra:  result = $signed(b) >>> shamt;   // keep sign
      default:  result = '0;                     // unused codes
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                clk,
  input  mips_pkg::wb_t       wb,
  input  mips_pkg::reg_addr_t rd_addr_1,
  input  mips_pkg::reg_addr_t rd_addr_2,
  output mips_pkg::word_t     rd_data_1,
  output mips_pkg::word_t     rd_data_2
);
  import mips_pkg::*;

  word_t regs [32];
  logic  wr_en;

  assign wr_en = wb.write_reg && (wb.dst != reg_ra_zero);  // r0 never written

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wb.dst] <= wb.data;
    end
  end

  // same-cycle write seen by readers
  assign rd_data_1 = (rd_addr_1 == reg_ra_zero)          ? '0      :
                     (wr_en && (wb.dst == rd_addr_1))    ? wb.data :
                                                           regs[rd_addr_1];
  assign rd_data_2 = (rd_addr_2 == reg_ra_zero)          ? '0      :
                     (wr_en && (wb.dst == rd_addr_2))    ? wb.data :
                                                           regs[rd_addr_2];

endmodule

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  input  logic             stall,
  output logic [29:0]      inst_mem_addr,
  input  mips_pkg::word_t  inst_mem_data,
  output mips_pkg::inst_t  inst_d
);

  logic [29:0] pc;       // word address
  logic        advance;

  assign advance       = run && !stall;  // frozen on stall or halt
  assign inst_mem_addr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;                    // boot at word 0
    end else if (advance) begin
      pc <= pc + 30'd1;            // next word
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inst_d <= '0;                // all-zero word is a nop
    end else if (advance) begin
      inst_d <= inst_mem_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  mips_pkg::inst_t    inst_d,
  input  mips_pkg::ctrl_t    ctrl,
  output logic [5:0]         opcode,
  output logic [5:0]         fcode,
  input  mips_pkg::wb_t      wb,
  input  mips_pkg::ex_mem_t  ex_mem,
  output logic               stall,
  output mips_pkg::id_ex_t   id_ex
);
  import mips_pkg::*;

  word_t  rd_data_1;
  word_t  rd_data_2;
  word_t  imm_ext;
  id_ex_t id_ex_d;      // next decode-to-execute contents
  logic   load_use;     // load in execute feeds this inst

  assign opcode = inst_d.r.opcode;  // to external controller
  assign fcode  = inst_d.r.funct;

  regfile rf_unit (
    .clk,
    .wb,
    .rd_addr_1 (inst_d.i.rs),
    .rd_addr_2 (inst_d.i.rt),
    .rd_data_1,
    .rd_data_2
  );

  always_comb begin
    case (ctrl.imm_ext)
      ext_sign: imm_ext = {{16{inst_d.i.imm[15]}}, inst_d.i.imm};
      ext_zero: imm_ext = {16'h0000, inst_d.i.imm};
      ext_swap: imm_ext = {inst_d.i.imm, 16'h0000};  // lui
      default:  imm_ext = {{16{inst_d.i.imm[15]}}, inst_d.i.imm};
    endcase
  end

  assign load_use = id_ex.mem.alu_or_mem && id_ex.mem.write_reg &&
                    ((id_ex.rt == inst_d.i.rs) || (id_ex.rt == inst_d.i.rt));
  assign stall    = run && load_use;  // one cycle per load

  always_comb begin
    id_ex_d.mem.write_reg   = ctrl.write_reg;
    id_ex_d.mem.write_mem   = ctrl.write_mem;
    id_ex_d.mem.alu_or_mem  = ctrl.alu_or_mem;
    id_ex_d.mem.mem_partial = ctrl.mem_partial;
    id_ex_d.mem.mem_op      = ctrl.mem_op;
    id_ex_d.alu_src_b       = ctrl.alu_src_b;
    id_ex_d.alu_op          = ctrl.alu_op;
    id_ex_d.reg_dst         = ctrl.reg_dst;
    id_ex_d.a               = rd_data_1;
    id_ex_d.b               = rd_data_2;
    id_ex_d.rs              = inst_d.i.rs;
    id_ex_d.rt              = inst_d.i.rt;
    id_ex_d.rd              = inst_d.r.rd;
    id_ex_d.shamt           = inst_d.r.shamt;
    id_ex_d.imm             = imm_ext;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex <= '0;                        // bubble
    end else if (run) begin
      id_ex <= stall ? '0 : id_ex_d;      // bubble behind the load
    end
  end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  mips_pkg::id_ex_t   id_ex,
  input  mips_pkg::wb_t      wb,
  output mips_pkg::ex_mem_t  ex_mem
);
  import mips_pkg::*;

  word_t     src_a;       // forwarded rs
  word_t     src_b;       // forwarded rt, also store data
  word_t     alu_b;
  word_t     alu_result;
  reg_addr_t dst;
  ex_mem_t   ex_mem_d;

  // newest producer wins: memory stage, then writeback
  function automatic word_t fwd_operand(reg_addr_t src, word_t reg_val,
                                        ex_mem_t mem_q, wb_t wb_q);
    word_t val;
    if (src == reg_ra_zero) begin
      val = reg_val;                              // r0 never forwarded
    end else if (mem_q.mem.write_reg && (mem_q.dst == src)) begin
      val = mem_q.result;
    end else if (wb_q.write_reg && (wb_q.dst == src)) begin
      val = wb_q.data;
    end else begin
      val = reg_val;
    end
    return val;
  endfunction

  assign src_a = fwd_operand(id_ex.rs, id_ex.a, ex_mem, wb);
  assign src_b = fwd_operand(id_ex.rt, id_ex.b, ex_mem, wb);
  assign alu_b = id_ex.alu_src_b ? id_ex.imm : src_b;  // imm or reg
  assign dst   = id_ex.reg_dst ? id_ex.rd : id_ex.rt;  // r-type writes rd

  alu alu_unit (
    .op     (id_ex.alu_op),
    .a      (src_a),
    .b      (alu_b),
    .shamt  (id_ex.shamt),
    .result (alu_result)
  );

  always_comb begin
    ex_mem_d.mem        = id_ex.mem;
    ex_mem_d.result     = alu_result;
    ex_mem_d.store_data = src_b;
    ex_mem_d.dst        = dst;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem <= '0;           // bubble, no store
    end else if (run) begin
      ex_mem <= ex_mem_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  mips_pkg::ex_mem_t  ex_mem,
  output logic               data_mem_we,
  output logic [3:0]         data_mem_be,
  output logic [29:0]        data_mem_addr,
  output mips_pkg::word_t    data_mem_wdata,
  input  mips_pkg::word_t    data_mem_rdata,
  output mips_pkg::wb_t      wb
);
  import mips_pkg::*;

  logic [1:0]  lo_addr;     // byte offset in word
  logic [7:0]  load_byte;
  logic [15:0] load_half;
  word_t       load_data;
  logic        wb_write_reg;
  logic        wb_from_mem;
  reg_addr_t   wb_dst;
  word_t       wb_alu;
  word_t       wb_load;

  assign lo_addr       = ex_mem.result[1:0];
  assign data_mem_we   = run && ex_mem.mem.write_mem;  // no write while frozen
  assign data_mem_addr = ex_mem.result[31:2];

  always_comb begin
    data_mem_be    = 4'b1111;                      // full word
    data_mem_wdata = ex_mem.store_data;
    if (ex_mem.mem.mem_partial) begin
      case (ex_mem.mem.mem_op)
        mem_ubyte, mem_sbyte: begin
          data_mem_be    = 4'b0001 << lo_addr;     // one lane
          data_mem_wdata = {4{ex_mem.store_data[7:0]}};
        end
        mem_uhalf, mem_shalf: begin
          data_mem_be    = lo_addr[1] ? 4'b1100 : 4'b0011;
          data_mem_wdata = {2{ex_mem.store_data[15:0]}};
        end
      endcase
    end
  end

  assign load_byte = data_mem_rdata[8*lo_addr +: 8];
  assign load_half = lo_addr[1] ? data_mem_rdata[31:16] : data_mem_rdata[15:0];

  always_comb begin
    load_data = data_mem_rdata;                    // lw
    if (ex_mem.mem.mem_partial) begin
      case (ex_mem.mem.mem_op)
        mem_ubyte: load_data = {24'd0, load_byte};
        mem_uhalf: load_data = {16'd0, load_half};
        mem_sbyte: load_data = {{24{load_byte[7]}}, load_byte};
        mem_shalf: load_data = {{16{load_half[15]}}, load_half};
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_write_reg <= 1'b0;
      wb_from_mem  <= 1'b0;
    end else if (run) begin
      wb_write_reg <= ex_mem.mem.write_reg;
      wb_from_mem  <= ex_mem.mem.alu_or_mem;
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      wb_dst  <= ex_mem.dst;
      wb_alu  <= ex_mem.result;
      wb_load <= load_data;
    end
  end

  assign wb = '{write_reg: wb_write_reg,
                dst:       wb_dst,
                data:      wb_from_mem ? wb_load : wb_alu};  // writeback select

endmodule

`default_nettype wire

// File: verilog/mips_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mips_datapath (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  output logic [29:0]      inst_mem_addr,
  input  mips_pkg::word_t  inst_mem_data,
  output logic [5:0]       opcode,
  output logic [5:0]       fcode,
  input  mips_pkg::ctrl_t  ctrl,
  output logic             data_mem_we,
  output logic [3:0]       data_mem_be,
  output logic [29:0]      data_mem_addr,
  output mips_pkg::word_t  data_mem_wdata,
  input  mips_pkg::word_t  data_mem_rdata
);
  import mips_pkg::*;

  inst_t   inst_d;   // fetch to decode
  logic    stall;    // load-use hold
  id_ex_t  id_ex;    // decode to execute
  ex_mem_t ex_mem;   // execute to memory
  wb_t     wb;       // regfile write, 2nd fwd level

  fetch_stage fetch_unit (
    .clk, .rst_n, .run, .stall,
    .inst_mem_addr, .inst_mem_data, .inst_d
  );

  decode_stage decode_unit (
    .clk, .rst_n, .run, .inst_d, .ctrl,
    .opcode, .fcode, .wb, .ex_mem, .stall, .id_ex
  );

  execute_stage execute_unit (
    .clk, .rst_n, .run, .id_ex, .wb, .ex_mem
  );

  memory_stage memory_unit (
    .clk, .rst_n, .run, .ex_mem,
    .data_mem_we, .data_mem_be, .data_mem_addr, .data_mem_wdata, .data_mem_rdata,
    .wb
  );

endmodule

`default_nettype wire

// File: bench/mips_datapath_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mips_datapath_properties (
  input logic        clk,
  input logic        rst_n,
  input logic        run,
  input logic        stall,
  input logic        data_mem_we,
  input logic [3:0]  data_mem_be,
  input logic [29:0] inst_mem_addr
);

  int n_failures = 0;  // failed assertion count

  we_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !data_mem_we)
    else begin
      $error("data_mem_we high in the first cycle after reset");
      n_failures++;
    end

  be_legal: assert property (@(posedge clk) disable iff (!rst_n)
    data_mem_we |-> data_mem_be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                        4'b0011, 4'b1100, 4'b1111})
    else begin
      $error("illegal data_mem_be pattern %b", data_mem_be);
      n_failures++;
    end

  pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    !run |=> $stable(inst_mem_addr))  // halt holds fetch
    else begin
      $error("inst_mem_addr moved while run was low");
      n_failures++;
    end

  stall_single: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> !stall)                 // one bubble per load
    else begin
      $error("load-use stall lasted two cycles");
      n_failures++;
    end

endmodule

bind mips_datapath mips_datapath_properties props_unit (
  .clk, .rst_n, .run, .stall, .data_mem_we, .data_mem_be, .inst_mem_addr
);

`default_nettype wire

// File: bench/tb_mips_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_datapath;
  import mips_pkg::*;

  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_slti    = 6'h0a;
  localparam logic [5:0] op_sltiu   = 6'h0b;
  localparam logic [5:0] op_andi    = 6'h0c;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_xori    = 6'h0e;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_lb      = 6'h20;
  localparam logic [5:0] op_lh      = 6'h21;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_lbu     = 6'h24;
  localparam logic [5:0] op_lhu     = 6'h25;
  localparam logic [5:0] op_sb      = 6'h28;
  localparam logic [5:0] op_sh      = 6'h29;
  localparam logic [5:0] op_sw      = 6'h2b;
  localparam logic [5:0] f_sll      = 6'h00;
  localparam logic [5:0] f_srl      = 6'h02;
  localparam logic [5:0] f_sra      = 6'h03;
  localparam logic [5:0] f_addu     = 6'h21;
  localparam logic [5:0] f_subu     = 6'h23;
  localparam logic [5:0] f_and      = 6'h24;
  localparam logic [5:0] f_or       = 6'h25;
  localparam logic [5:0] f_xor      = 6'h26;
  localparam logic [5:0] f_nor      = 6'h27;
  localparam logic [5:0] f_slt      = 6'h2a;
  localparam logic [5:0] f_sltu     = 6'h2b;

  typedef struct packed {
    logic [29:0] addr;   // word address
    logic [3:0]  be;
    word_t       data;   // enabled lanes only
  } store_t;

  logic [5:0]  alu_functs [8]   = '{f_addu, f_subu, f_and, f_or, f_xor, f_nor, f_slt, f_sltu};
  logic [5:0]  shift_functs [3] = '{f_sll, f_srl, f_sra};
  logic [5:0]  imm_ops [7]      = '{op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui};
  logic [15:0] load_bases [2]   = '{16'h0010, 16'h0024};  // stored word, then fill word

  logic        clk;
  logic        rst_n;
  logic        run;
  logic [29:0] inst_mem_addr;
  word_t       inst_mem_data;
  logic [5:0]  opcode;
  logic [5:0]  fcode;
  ctrl_t       ctrl;
  logic        data_mem_we;
  logic [3:0]  data_mem_be;
  logic [29:0] data_mem_addr;
  word_t       data_mem_wdata;
  word_t       data_mem_rdata;

  integer      seed;
  word_t       val;
  logic [15:0] res_addr;       // next result slot
  word_t       prog [$];
  word_t       imem [256];
  word_t       dmem [128];
  store_t      exp_q [$];      // expected store sequence
  int          n_checked    = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  logic        timed_out;

  mips_datapath i_dut (
    .clk, .rst_n, .run, .inst_mem_addr, .inst_mem_data, .opcode, .fcode, .ctrl,
    .data_mem_we, .data_mem_be, .data_mem_addr, .data_mem_wdata, .data_mem_rdata
  );

  function automatic word_t r_type(logic [5:0] funct, reg_addr_t rs, reg_addr_t rt,
                                   reg_addr_t rd, logic [4:0] shamt);
    inst_t w;
    w.r.opcode = op_special;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    w.r.shamt  = shamt;
    w.r.funct  = funct;
    return w;
  endfunction

  function automatic word_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                   logic [15:0] imm);
    inst_t w;
    w.i.opcode = op;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = imm;
    return w;
  endfunction

  task automatic store_result(reg_addr_t r);
    prog.push_back(i_type(op_sw, reg_ra_zero, r, res_addr));
    res_addr += 16'd4;
  endtask

  function automatic word_t fill_word(int idx);
    return word_t'(idx + 1) * 32'h9e37_79b9;  // every byte varies with the index
  endfunction

  function automatic word_t lane_mask(logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  function automatic ctrl_t immediate_ctrl(alu_op_t op, imm_ext_t ext);
    ctrl_t c;
    c           = '0;
    c.write_reg = 1'b1;
    c.alu_src_b = 1'b1;
    c.alu_op    = op;
    c.imm_ext   = ext;
    return c;
  endfunction

  // isa-level model, builds exp_q
  function automatic void run_reference(int n_inst);
    word_t       regs [32];
    word_t       mem [128];
    inst_t       in;
    word_t       rs_v;
    word_t       rt_v;
    word_t       simm;
    word_t       addr;
    word_t       word;
    word_t       res;
    logic [1:0]  off;
    logic [15:0] half;
    logic [3:0]  be;
    int          i;
    int          pc;
    for (i = 0; i < 128; i++) mem[i] = fill_word(i);
    for (i = 0; i < 32; i++) regs[i] = '0;
    for (pc = 0; pc < n_inst; pc++) begin
      in   = imem[pc];
      rs_v = regs[in.i.rs];
      rt_v = regs[in.i.rt];
      simm = {{16{in.i.imm[15]}}, in.i.imm};
      addr = rs_v + simm;                          // effective address
      off  = addr[1:0];
      word = mem[addr[8:2]];
      half = off[1] ? word[31:16] : word[15:0];
      case (in.i.opcode)
        op_special: begin
          case (in.r.funct)
            f_addu:  res = rs_v + rt_v;
            f_subu:  res = rs_v - rt_v;
            f_and:   res = rs_v & rt_v;
            f_or:    res = rs_v | rt_v;
            f_xor:   res = rs_v ^ rt_v;
            f_nor:   res = ~(rs_v | rt_v);
            f_slt:   res = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
            f_sltu:  res = (rs_v < rt_v) ? 32'd1 : 32'd0;
            f_sll:   res = rt_v << in.r.shamt;
            f_srl:   res = rt_v >> in.r.shamt;
            f_sra:   res = $signed(rt_v) >>> in.r.shamt;
            default: res = '0;
          endcase
          regs[in.r.rd] = res;
        end
        op_addiu: regs[in.i.rt] = rs_v + simm;
        op_slti:  regs[in.i.rt] = ($signed(rs_v) < $signed(simm)) ? 32'd1 : 32'd0;
        op_sltiu: regs[in.i.rt] = (rs_v < simm) ? 32'd1 : 32'd0;  // sign-extended imm
        op_andi:  regs[in.i.rt] = rs_v & {16'h0000, in.i.imm};
        op_ori:   regs[in.i.rt] = rs_v | {16'h0000, in.i.imm};
        op_xori:  regs[in.i.rt] = rs_v ^ {16'h0000, in.i.imm};
        op_lui:   regs[in.i.rt] = {in.i.imm, 16'h0000};
        op_lb:    regs[in.i.rt] = {{24{word[8*off+7]}}, word[8*off +: 8]};
        op_lbu:   regs[in.i.rt] = {24'd0, word[8*off +: 8]};
        op_lh:    regs[in.i.rt] = {{16{half[15]}}, half};
        op_lhu:   regs[in.i.rt] = {16'd0, half};
        op_lw:    regs[in.i.rt] = word;
        op_sb, op_sh, op_sw: begin
          be = (in.i.opcode == op_sb) ? 4'b0001 << off :
               (in.i.opcode == op_sh) ? 4'b0011 << off : 4'b1111;
          res = (rt_v << (8*off)) & lane_mask(be);   // rt moved to its lanes
          mem[addr[8:2]] = (word & ~lane_mask(be)) | res;
          exp_q.push_back('{addr[31:2], be, res});
        end
        default: ;
      endcase
      regs[0] = '0;
    end
  endfunction

  task automatic check_word(string name, word_t act, word_t exp);
    if (act !== exp) begin
      $display("FAILED t=%0t %s: got %h, expected %h", $time, name, act, exp);
      value_errors++;
    end
  endtask

  task automatic check_be(logic [3:0] act, logic [3:0] exp);
    if (act !== exp) begin
      $display("FAILED t=%0t data_mem_be: got %b, expected %b", $time, act, exp);
      value_errors++;
    end
  endtask

  task automatic wait_for_stores(int count, output logic late);
    int cycles;
    cycles = 0;
    while (n_checked < count && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    late = (n_checked < count);
    if (late) begin
      $display("ERROR: timed out after %0d cycles waiting for store %0d", cycles, count);
      other_errors++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // controller model, decodes opcode/fcode in the same cycle
  always_comb begin
    ctrl = '0;
    case (opcode)
      op_special: begin
        ctrl.write_reg = 1'b1;
        ctrl.reg_dst   = 1'b1;
        case (fcode)
          f_subu:  ctrl.alu_op = alu_sub;
          f_and:   ctrl.alu_op = alu_and;
          f_or:    ctrl.alu_op = alu_or;
          f_xor:   ctrl.alu_op = alu_xor;
          f_nor:   ctrl.alu_op = alu_nor;
          f_slt:   ctrl.alu_op = alu_slt;
          f_sltu:  ctrl.alu_op = alu_sltu;
          f_sll:   ctrl.alu_op = alu_sll;
          f_srl:   ctrl.alu_op = alu_srl;
          f_sra:   ctrl.alu_op = alu_sra;
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_addiu: ctrl = immediate_ctrl(alu_add, ext_sign);
      op_slti:  ctrl = immediate_ctrl(alu_slt, ext_sign);
      op_sltiu: ctrl = immediate_ctrl(alu_sltu, ext_sign);
      op_andi:  ctrl = immediate_ctrl(alu_and, ext_zero);
      op_ori:   ctrl = immediate_ctrl(alu_or, ext_zero);
      op_xori:  ctrl = immediate_ctrl(alu_xor, ext_zero);
      op_lui:   ctrl = immediate_ctrl(alu_or, ext_swap);   // rs is r0
      op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
        ctrl             = immediate_ctrl(alu_add, ext_sign);
        ctrl.alu_or_mem  = 1'b1;
        ctrl.mem_partial = (opcode != op_lw);
        case (opcode)
          op_lb:   ctrl.mem_op = mem_sbyte;
          op_lh:   ctrl.mem_op = mem_shalf;
          op_lhu:  ctrl.mem_op = mem_uhalf;
          default: ctrl.mem_op = mem_ubyte;
        endcase
      end
      op_sb, op_sh, op_sw: begin
        ctrl             = immediate_ctrl(alu_add, ext_sign);
        ctrl.write_reg   = 1'b0;
        ctrl.write_mem   = 1'b1;
        ctrl.mem_partial = (opcode != op_sw);
        ctrl.mem_op      = (opcode == op_sh) ? mem_uhalf : mem_ubyte;
      end
      default: ;
    endcase
  end

  assign inst_mem_data  = imem[inst_mem_addr[7:0]];
  assign data_mem_rdata = dmem[data_mem_addr[6:0]];

  // byte-enabled data memory
  always @(posedge clk) begin : data_mem_write
    int b;
    if (data_mem_we === 1'b1) begin
      for (b = 0; b < 4; b++) begin
        if (data_mem_be[b]) dmem[data_mem_addr[6:0]][8*b +: 8] <= data_mem_wdata[8*b +: 8];
      end
    end
  end

  always @(posedge clk) begin : compare_stores
    store_t want;
    if (rst_n === 1'b1 && data_mem_we === 1'b1 && run !== 1'b1) begin
      $display("ERROR: t=%0t store issued while run was low", $time);
      other_errors++;
    end else if (rst_n === 1'b1 && data_mem_we === 1'b1) begin
      if (n_checked < exp_q.size()) begin
        want = exp_q[n_checked];
        check_word("data_mem_addr", {2'b00, data_mem_addr}, {2'b00, want.addr});
        check_be(data_mem_be, want.be);
        check_word("data_mem_wdata", data_mem_wdata & lane_mask(want.be), want.data);
      end else begin
        $display("ERROR: t=%0t store beyond the end of the expected sequence", $time);
        other_errors++;
      end
      n_checked++;
    end
  end

  initial begin : stimulus
    int r;
    int k;
    int b;
    int off;
    int assert_errors;
    seed     = 69116;
    res_addr = 16'h0100;       // result area
    rst_n    = 1'b0;
    run      = 1'b1;
    for (k = 0; k < 128; k++) dmem[k] = fill_word(k);
    for (r = 1; r <= 8; r++) begin       // random constants, ori leans on forwarding
      val = $random(seed);
      prog.push_back(i_type(op_lui, reg_ra_zero, reg_addr_t'(r), val[31:16]));
      prog.push_back(i_type(op_ori, reg_addr_t'(r), reg_addr_t'(r), val[15:0]));
    end
    for (k = 0; k < 8; k++) begin
      prog.push_back(r_type(alu_functs[k], reg_addr_t'(k + 1), reg_addr_t'(8 - k), 5'd9, 5'd0));
      store_result(5'd9);
    end
    for (k = 0; k < 3; k++) begin
      val = $random(seed);
      prog.push_back(r_type(shift_functs[k], reg_ra_zero, reg_addr_t'(k + 3), 5'd9, val[4:0]));
      store_result(5'd9);
    end
    for (k = 0; k < 7; k++) begin
      val = $random(seed);
      prog.push_back(i_type(imm_ops[k], (imm_ops[k] == op_lui) ? reg_ra_zero : reg_addr_t'(k + 1),
                            5'd10, val[15:0]));
      store_result(5'd10);
    end
    prog.push_back(r_type(f_addu, 5'd1, 5'd2, 5'd11, 5'd0));
    prog.push_back(r_type(f_xor, 5'd3, 5'd4, 5'd12, 5'd0));
    prog.push_back(r_type(f_subu, 5'd11, 5'd12, 5'd13, 5'd0));  // r11 from wb, r12 from mem
    store_result(5'd13);
    prog.push_back(i_type(op_sw, reg_ra_zero, 5'd5, 16'h0080));
    prog.push_back(i_type(op_lw, reg_ra_zero, 5'd14, 16'h0080));
    prog.push_back(r_type(f_addu, 5'd14, 5'd6, 5'd15, 5'd0));   // load-use stall
    store_result(5'd15);
    prog.push_back(i_type(op_lw, reg_ra_zero, 5'd16, 16'h0080));
    store_result(5'd16);                                        // store data waits on load
    for (off = 0; off < 4; off++) prog.push_back(i_type(op_sb, reg_ra_zero, 5'd7, 16'(off)));
    prog.push_back(i_type(op_sh, reg_ra_zero, 5'd8, 16'h0004));
    prog.push_back(i_type(op_sh, reg_ra_zero, 5'd8, 16'h0006));
    prog.push_back(i_type(op_addiu, reg_ra_zero, 5'd20, 16'h0008));
    prog.push_back(i_type(op_sb, 5'd20, 5'd6, 16'h0003));       // forwarded base
    prog.push_back(i_type(op_sw, reg_ra_zero, 5'd1, 16'h0010));
    for (b = 0; b < 2; b++) begin
      for (off = 0; off < 4; off++) begin
        prog.push_back(i_type(op_lb, reg_ra_zero, 5'd17, load_bases[b] + 16'(off)));
        store_result(5'd17);
        prog.push_back(i_type(op_lbu, reg_ra_zero, 5'd17, load_bases[b] + 16'(off)));
        store_result(5'd17);
        if (off % 2 == 0) begin
          prog.push_back(i_type(op_lh, reg_ra_zero, 5'd18, load_bases[b] + 16'(off)));
          store_result(5'd18);
          prog.push_back(i_type(op_lhu, reg_ra_zero, 5'd18, load_bases[b] + 16'(off)));
          store_result(5'd18);
        end
      end
    end
    for (k = 0; k < 8; k++) prog.push_back('0);                 // drain with nops
    for (k = 0; k < 256; k++) imem[k] = (k < prog.size()) ? prog[k] : '0;
    run_reference(prog.size());
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    wait_for_stores(12, timed_out);
    if (!timed_out) begin
      @(posedge clk);
      #1 run = 1'b0;                                            // freeze mid-program
      repeat (6) @(posedge clk);
      #1 run = 1'b1;
      wait_for_stores(exp_q.size(), timed_out);
    end
    if (!timed_out) repeat (20) @(posedge clk);                // catch stray stores
    assert_errors = i_dut.props_unit.n_failures;
    $display("errors: %0d value, %0d other, %0d assertion, %0d of %0d stores seen",
             value_errors, other_errors, assert_errors, n_checked, exp_q.size());
    if (timed_out || value_errors != 0 || other_errors != 0 || assert_errors != 0) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mips_datapath.f
verilog/mips_pkg.sv
verilog/alu.sv
verilog/regfile.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/mips_datapath.sv
bench/mips_datapath_properties.sv
bench/tb_mips_datapath.sv

// File: Bender.yml
package:
  name: mips_datapath

sources:
  - verilog/mips_pkg.sv
  - verilog/alu.sv
  - verilog/regfile.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/memory_stage.sv
  - verilog/mips_datapath.sv
  - target: simulation
    files:
      - bench/mips_datapath_properties.sv
      - bench/tb_mips_datapath.sv
